//--- bench/audio_stim.txt
# op offset data expected name, numbers in hex; rdback data = random bits taken, read data = select
# frame ops zero/square/saw/mix: offset = frames skipped, data = frames checked, expected = saw Hz
zero    0 8    0    silence_after_reset
rdback  0 10   0    readback_saw_freq
rdback  1 2    0    readback_saw_duration
rdback  2 10   0    readback_square_freq
rdback  3 2    0    readback_square_duration
read    4 1    ffff unmapped_offset_4
read    f 1    ffff unmapped_offset_f
read    0 0    ffff select_low
frames  0 14   0    wait_random_tones
write   2 1770 0    set_square_6000hz
write   3 3    0    start_square_3ms
square  0 c    0    square_tone
frames  0 3    0    wait_square_end
zero    0 8    0    square_silent_again
write   0 3e8  0    set_saw_1000hz
write   1 4    0    start_saw_4ms
saw     0 10   3e8  saw_tone
frames  0 3    0    wait_saw_end
write   3 6    0    start_square_6ms
write   1 6    0    start_saw_6ms
mix     4 10   3e8  mix_tones
frames  0 9    0    wait_mix_end
zero    0 8    0    mix_silent_again
write   3 0    0    zero_square_duration
write   1 0    0    zero_saw_duration
zero    0 a    0    zero_duration_silent

//--- vlog.f
rtl/audio_pkg.sv
rtl/audio_regs.sv
rtl/tone_synth.sv
rtl/sample_fifo.sv
rtl/i2s_tx.sv
rtl/audio_top.sv
bench/tb_clock.sv
bench/tb_audio.sv

//--- run_sim.sh
#!/bin/bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_audio -f vlog.f
./obj_dir/Vtb_audio 2>&1 | tee sim.log

if grep -q '>>> FAIL' sim.log; then
    exit 1
fi

//--- bench/tb_audio.sv
`timescale 1ns/1ns

module tb_audio;
    import audio_pkg::*;

    localparam int EDGE_TIMEOUT = 600;  // More than one LRCK half of 256 cycles
    localparam int BIT_TIMEOUT  = 20;   // More than one SCLK period of 8 cycles
    localparam int RESET_WAIT   = 50;

    logic                clk_audio;
    logic                reset;
    reg_bus_t            bus;
    logic [SAMPLE_W-1:0] rdata;
    i2s_pins_t           pins;

    logic [15:0] lfsr;         // Random register data
    bit          timed_out;
    bit          test_failed;  // Current test only
    int          tests;
    int          failures;

    tb_clock u_clock (.clk_audio(clk_audio), .reset(reset));

    audio_top #(.TICKS_PER_MS(2048)) dut (  // One ms is four frames
        .clk_audio (clk_audio),
        .reset     (reset),
        .bus       (bus),
        .rdata     (rdata),
        .pins      (pins)
    );

    // ============================================================
    // Random data and register port
    // ============================================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);  // Galois taps 16,14,13,11
    endfunction

    task automatic take_random(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr[0]};  // One LFSR step per bit
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic write_reg(input logic [3:0] offset, input logic [15:0] data);
        @(negedge clk_audio);
        bus = '{select: 1'b1, offset: offset, read: 1'b0, write: 1'b1, wdata: data};
        @(negedge clk_audio);
        bus = '0;
    endtask

    task automatic read_reg(input logic [3:0] offset, input logic sel, output logic [15:0] data);
        @(negedge clk_audio);
        bus = '{select: sel, offset: offset, read: 1'b1, write: 1'b0, wdata: '0};
        @(negedge clk_audio);
        data = rdata;  // Combinational read settled by now
        bus  = '0;
    endtask

    // ============================================================
    // I2S receiver
    // ============================================================
    task automatic wait_lrck(input logic level);
        int n;
        n = 0;
        while (pins.lrck !== level && !timed_out) begin
            @(negedge clk_audio);
            n++;
            if (n > EDGE_TIMEOUT) begin
                $display("Timeout: LRCK never went to %0b", level);
                timed_out = 1'b1;
            end
        end
    endtask

    // Starts just after an LRCK edge and takes the MSB on the second SCLK rise
    task automatic shift_word(output logic [15:0] word);
        int   rises;
        int   n;
        logic prev;
        word  = '0;
        rises = 0;
        n     = 0;
        prev  = pins.sclk;  // Already high from the LRCK edge
        while (rises < SAMPLE_W + 1 && !timed_out) begin
            @(negedge clk_audio);
            n++;
            if (pins.sclk && !prev) begin
                rises++;
                n = 0;
                if (rises > 1) word = {word[14:0], pins.sdin};  // Bit held across the rise
            end
            prev = pins.sclk;
            if (n > BIT_TIMEOUT) begin
                $display("Timeout: SCLK stopped toggling");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic read_frame(output logic [15:0] left, output logic [15:0] right);
        wait_lrck(1'b0);
        wait_lrck(1'b1);  // Frame starts on the rising LRCK edge
        shift_word(left);
        wait_lrck(1'b0);
        shift_word(right);
    endtask

    // ============================================================
    // Checks
    // ============================================================
    function automatic bit near_step(input logic [15:0] diff, input logic [15:0] step,
                                     input int tol);
        logic signed [15:0] err;
        err = diff - step;  // Modulo 2^16
        return (err >= -tol) && (err <= tol);
    endfunction

    // Doubled word minus some legal square level must step like the sawtooth
    function automatic bit mix_step_ok(input logic [15:0] prev, input logic [15:0] cur,
                                       input logic [15:0] step);
        logic [15:0] prev_saw;
        logic [15:0] cur_saw;
        bit          ok;
        ok = 1'b0;
        for (int a = 0; a < 2; a++) begin
            for (int b = 0; b < 2; b++) begin
                prev_saw = (prev << 1) - ((a == 0) ? SQUARE_HIGH : SQUARE_LOW);
                cur_saw  = (cur << 1) - ((b == 0) ? SQUARE_HIGH : SQUARE_LOW);
                if (near_step(cur_saw - prev_saw, step, 2)) ok = 1'b1;
            end
        end
        return ok;
    endfunction

    task automatic flag_error(input string name, input int where,
                              input logic [15:0] expected, input logic [15:0] actual);
        $display("** Error %0s at %0d: expected %h, actual %h", name, where, expected, actual);
        test_failed = 1'b1;
    endtask

    task automatic finish_test(input string name);
        if (timed_out) test_failed = 1'b1;
        if (test_failed) begin
            $display("test %0s failed", name);
            failures++;
        end else begin
            $display("test %0s passed", name);
        end
        tests++;
    endtask

    task automatic check_frames(input string op, input string name, input int skip,
                                input int count, input int freq);
        logic [15:0] left;
        logic [15:0] right;
        logic [15:0] prev;
        logic [15:0] step;   // Sawtooth step per frame
        logic [15:0] diff;
        bit          seen;   // A square level came out
        int          steps;  // Frame pairs compared
        prev  = '0;
        seen  = 1'b0;
        steps = 0;
        step  = 16'((longint'(freq) * longint'(PHASE_PER_HZ)) >> 16);
        for (int i = 0; i < skip; i++) begin
            read_frame(left, right);  // Start-up frames not checked
        end
        for (int i = 0; i < count && !timed_out; i++) begin
            read_frame(left, right);
            diff = left - prev;
            if (right != left) flag_error(name, i, left, right);  // Same word in both halves
            if (op == "zero" && left != '0) begin
                flag_error(name, i, 16'h0000, left);
            end else if (op == "square") begin
                if (left == SQUARE_HIGH || left == SQUARE_LOW) begin
                    seen = 1'b1;
                end else if (left != '0 || seen) begin  // Zeros only while it starts
                    flag_error(name, i, left[15] ? SQUARE_LOW : SQUARE_HIGH, left);
                end
            end else if (op == "saw" && left != '0 && prev != '0) begin
                steps++;
                if (!near_step(diff, step, 1)) flag_error(name, i, step, diff);
            end else if (op == "mix" && i > 0) begin
                steps++;
                if (!mix_step_ok(prev, left, step)) flag_error(name, i, step, diff);
            end
            prev = left;
        end
        if ((op == "square" && !seen) || ((op == "saw" || op == "mix") && steps == 0)) begin
            $display("%0s: the tone never showed up on sdin", name);
            test_failed = 1'b1;
        end
    endtask

    task automatic run_step(input string op, input int offset, input int data,
                            input int expected, input string name);
        logic [15:0] value;
        logic [15:0] prior;
        logic [15:0] got;
        logic [15:0] right;
        test_failed = 1'b0;
        if (op == "write") begin
            write_reg(4'(offset), 16'(data));
        end else if (op == "frames") begin
            for (int i = 0; i < data && !timed_out; i++) begin
                read_frame(value, right);  // Just let time pass
            end
        end else if (op == "rdback") begin
            read_reg(4'(offset), 1'b1, prior);  // Content before the write
            take_random(data, value);
            while (value == prior) take_random(data, value);  // New value must differ
            write_reg(4'(offset), value);
            read_reg(4'(offset), 1'b1, got);
            if (got != value) flag_error(name, offset, value, got);
            finish_test(name);
        end else if (op == "read") begin
            read_reg(4'(offset), data[0], got);  // data picks select
            if (got != 16'(expected)) flag_error(name, offset, 16'(expected), got);
            finish_test(name);
        end else if (op == "zero" || op == "square" || op == "saw" || op == "mix") begin
            check_frames(op, name, offset, data, expected);
            finish_test(name);
        end else begin
            $display("Unknown stim op %0s in step %0s", op, name);
            failures++;
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        int    fd;
        int    fields;
        int    n;
        int    offset;
        int    data;
        int    expected;
        string line;
        string op;
        string name;
        bus         = '0;
        lfsr        = 16'd80;  // Seed
        timed_out   = 1'b0;
        test_failed = 1'b0;
        tests       = 0;
        failures    = 0;
        @(negedge clk_audio);
        n = 0;
        while (reset !== 1'b0 && n < RESET_WAIT) begin
            @(negedge clk_audio);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        fd = $fopen("bench/audio_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/audio_stim.txt");
            failures++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // Blank or comment
                fields = $sscanf(line, "%s %h %h %h %s", op, offset, data, expected, name);
                if (fields != 5) begin
                    $display("Malformed stim line: %0s", line);
                    failures++;
                end else begin
                    run_step(op, offset, data, expected, name);
                end
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d failed", tests, failures);
        if (failures == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk_audio,
    output logic reset
);
    localparam int HALF_PERIOD  = 50;  // 100 ns period
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_audio = 1'b0;
        forever #HALF_PERIOD clk_audio = ~clk_audio;
    end

    // Reset drops on a falling edge, clear of the DUT's sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_audio);
        @(negedge clk_audio);
        reset = 1'b0;
    end

endmodule

//--- rtl/audio_top.sv
`timescale 1ns/1ns

module audio_top #(
    parameter int TICKS_PER_MS = 24576  // Millisecond length in clk_audio cycles
) (
    input  logic                           clk_audio,
    input  logic                           reset,
    input  audio_pkg::reg_bus_t            bus,
    output logic [audio_pkg::SAMPLE_W-1:0] rdata,
    output audio_pkg::i2s_pins_t           pins
);
    import audio_pkg::*;

    tone_cfg_t                  saw_cfg;
    tone_cfg_t                  square_cfg;
    logic                       saw_start;
    logic                       square_start;
    logic                       push;
    logic                       pop;
    logic                       full;
    logic                       empty;
    logic signed [SAMPLE_W-1:0] synth_sample;  // Producer to buffer
    logic [SAMPLE_W-1:0]        head_sample;   // Buffer to serializer

    audio_regs u_regs (
        .clk_audio    (clk_audio),
        .reset        (reset),
        .bus          (bus),
        .rdata        (rdata),
        .saw_cfg      (saw_cfg),
        .square_cfg   (square_cfg),
        .saw_start    (saw_start),
        .square_start (square_start)
    );

    tone_synth #(.TICKS_PER_MS(TICKS_PER_MS)) u_synth (
        .clk_audio    (clk_audio),
        .reset        (reset),
        .saw_cfg      (saw_cfg),
        .square_cfg   (square_cfg),
        .saw_start    (saw_start),
        .square_start (square_start),
        .full         (full),
        .push         (push),
        .sample       (synth_sample)
    );

    sample_fifo u_fifo (
        .clk_audio (clk_audio),
        .reset     (reset),
        .push      (push),
        .wr_sample (synth_sample),
        .pop       (pop),
        .rd_sample (head_sample),
        .full      (full),
        .empty     (empty)
    );

    i2s_tx u_i2s (
        .clk_audio (clk_audio),
        .reset     (reset),
        .sample    (head_sample),
        .empty     (empty),
        .pop       (pop),
        .pins      (pins)
    );

endmodule

//--- rtl/i2s_tx.sv
`timescale 1ns/1ns

module i2s_tx (
    input  logic                           clk_audio,
    input  logic                           reset,
    input  logic [audio_pkg::SAMPLE_W-1:0] sample,
    input  logic                           empty,
    output logic                           pop,
    output audio_pkg::i2s_pins_t           pins
);
    import audio_pkg::*;

    logic [$clog2(SCLK_HALF)-1:0]         div_cnt;   // Half SCLK divider
    logic [$clog2(SLOTS_PER_CHANNEL)-1:0] slot_cnt;  // SCLK periods in this half
    logic                                 sclk;
    logic                                 lrck;
    logic                                 sdin;
    logic                                 sclk_prev;
    logic                                 lrck_prev;
    logic                                 sclk_fall;
    logic                                 lrck_edge;
    logic                                 lrck_rise;   // Start of a frame
    i2s_state_e                           state;
    logic [SAMPLE_W-1:0]                  shift;
    logic [SAMPLE_W-1:0]                  hold;        // Word for the second half
    logic [SAMPLE_W-1:0]                  frame_word;
    logic [$clog2(SAMPLE_W):0]            bit_cnt;     // Bits sent, 0..16

    // ============================================================
    // SCLK and LRCK generation
    // ============================================================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            div_cnt  <= '0;
            slot_cnt <= '0;
            sclk     <= 1'b0;
            lrck     <= 1'b0;
        end else if (div_cnt == SCLK_HALF - 1) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (!sclk) begin  // Rising SCLK ends a period
                if (slot_cnt == SLOTS_PER_CHANNEL - 1) begin
                    slot_cnt <= '0;
                    lrck     <= ~lrck;  // New channel half
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Edge detection
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            sclk_prev <= 1'b0;
            lrck_prev <= 1'b0;
        end else begin
            sclk_prev <= sclk;
            lrck_prev <= lrck;
        end
    end

    assign sclk_fall  = sclk_prev && !sclk;
    assign lrck_edge  = lrck != lrck_prev;
    assign lrck_rise  = lrck && !lrck_prev;
    assign frame_word = empty ? '0 : sample;  // Underrun sends silence

    // ============================================================
    // Serializer FSM
    // ============================================================
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            state   <= WAIT_LRCK;
            bit_cnt <= '0;
            sdin    <= 1'b0;
            pop     <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                WAIT_LRCK: if (lrck_edge) begin
                    bit_cnt <= '0;
                    pop     <= lrck_rise && !empty;  // One pop per frame
                    state   <= DELAY_FIRST;
                end
                DELAY_FIRST: if (sclk_fall) begin
                    state <= TRANSMIT;  // MSB on the next falling edge
                end
                TRANSMIT: if (sclk_fall) begin
                    if (bit_cnt < SAMPLE_W) begin
                        sdin    <= shift[SAMPLE_W-1];
                        bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        sdin  <= 1'b0;  // Pad the rest of the half
                        state <= WAIT_LRCK;
                    end
                end
                default: state <= WAIT_LRCK;
            endcase
        end
    end

    // Shift register and repeat word
    always_ff @(posedge clk_audio) begin
        if (state == WAIT_LRCK && lrck_edge) begin
            if (lrck_rise) begin
                shift <= frame_word;
                hold  <= frame_word;
            end else begin
                shift <= hold;  // Same word again
            end
        end else if (state == TRANSMIT && sclk_fall && bit_cnt < SAMPLE_W) begin
            shift <= {shift[SAMPLE_W-2:0], 1'b0};
        end
    end

    assign pins.lrck = lrck;
    assign pins.sclk = sclk;
    assign pins.sdin = sdin;

    assert property (@(posedge clk_audio) disable iff (reset)
        state inside {WAIT_LRCK, DELAY_FIRST, TRANSMIT})
        else $error("i2s_tx: illegal FSM state");

endmodule

//--- rtl/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
    input  logic                           clk_audio,
    input  logic                           reset,
    input  logic                           push,
    input  logic [audio_pkg::SAMPLE_W-1:0] wr_sample,
    input  logic                           pop,
    output logic [audio_pkg::SAMPLE_W-1:0] rd_sample,
    output logic                           full,
    output logic                           empty
);
    import audio_pkg::*;

    logic [SAMPLE_W-1:0] mem [2];  // Two sample slots
    logic                wr_ptr;
    logic                rd_ptr;
    logic [1:0]          count;    // 0..2 entries
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;  // Pop on empty is a no-op

    always_ff @(posedge clk_audio) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ~wr_ptr;
            if (do_pop)  rd_ptr <= ~rd_ptr;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk_audio) begin
        if (do_push) mem[wr_ptr] <= wr_sample;
    end

    assign rd_sample = mem[rd_ptr];  // Head word, valid when not empty
    assign full      = (count == 2'd2);
    assign empty     = (count == 2'd0);

    // Producer must respect the full level
    assert property (@(posedge clk_audio) disable iff (reset) push |-> !full)
        else $error("sample_fifo: push while full");

endmodule

//--- rtl/tone_synth.sv
`timescale 1ns/1ns

module tone_synth #(
    parameter int TICKS_PER_MS = 24576  // clk_audio cycles per millisecond
) (
    input  logic                                   clk_audio,
    input  logic                                   reset,
    input  audio_pkg::tone_cfg_t                   saw_cfg,
    input  audio_pkg::tone_cfg_t                   square_cfg,
    input  logic                                   saw_start,
    input  logic                                   square_start,
    input  logic                                   full,
    output logic                                   push,
    output logic signed [audio_pkg::SAMPLE_W-1:0]  sample
);
    import audio_pkg::*;

    logic                       step;          // Advance one frame
    logic signed [SAMPLE_W-1:0] saw_voice;
    logic signed [SAMPLE_W-1:0] square_voice;
    logic signed [SAMPLE_W:0]   mix_sum;       // One guard bit for the average
    logic signed [SAMPLE_W-1:0] mix;

    // Pending push doubles as the frame-stepped flag
    assign step = !full && !push;

    // ============================================================
    // Per voice timer and phase, voice 0 saw, voice 1 square
    // ============================================================
    for (genvar v = 0; v < 2; v++) begin : g_voice
        tone_cfg_t          cfg;
        logic               start;
        logic               playing;
        logic               ms_tick;
        logic [31:0]        prescale;  // Cycles within the current ms
        logic [SAMPLE_W-1:0] ms_left;  // Remaining ms
        logic [PHASE_W-1:0] phase;

        assign cfg     = (v == 0) ? saw_cfg : square_cfg;
        assign start   = (v == 0) ? saw_start : square_start;
        assign ms_tick = playing && (prescale == TICKS_PER_MS - 1);

        // Millisecond countdown
        always_ff @(posedge clk_audio) begin
            if (reset) begin
                playing  <= 1'b0;
                prescale <= '0;
                ms_left  <= '0;
            end else if (start && cfg.duration != '0) begin
                playing  <= 1'b1;          // Zero duration never gets here
                prescale <= '0;            // Fresh ms boundary
                ms_left  <= cfg.duration;
            end else if (playing) begin
                if (ms_tick) begin
                    prescale <= '0;
                    ms_left  <= ms_left - 1'b1;
                    if (ms_left == 1) begin
                        playing <= 1'b0;  // Last ms done
                    end
                end else begin
                    prescale <= prescale + 1'b1;
                end
            end
        end

        // Phase accumulator, parked at zero while silent
        always_ff @(posedge clk_audio) begin
            if (reset || !playing) begin
                phase <= '0;
            end else if (step) begin
                phase <= phase + (PHASE_W'(cfg.freq) * PHASE_PER_HZ);
            end
        end
    end

    // ============================================================
    // Waveforms and mixer
    // ============================================================
    assign saw_voice = g_voice[0].playing
                     ? signed'(g_voice[0].phase[PHASE_W-1 -: SAMPLE_W] - SAW_OFFSET)
                     : '0;
    assign square_voice = !g_voice[1].playing      ? '0
                        : g_voice[1].phase[PHASE_W-1] ? SQUARE_HIGH
                        : SQUARE_LOW;

    assign mix_sum = saw_voice + square_voice;  // Sign extended to 17 bits

    always_comb begin
        case ({g_voice[0].playing, g_voice[1].playing})
            2'b11:   mix = mix_sum[SAMPLE_W:1];  // Arithmetic average
            2'b10:   mix = saw_voice;
            2'b01:   mix = square_voice;
            default: mix = '0;                   // Silence
        endcase
    end

    // Push strobe, one per step
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= step;
        end
    end

    always_ff @(posedge clk_audio) begin
        if (step) begin
            sample <= mix;  // Held under back-pressure
        end
    end

endmodule

//--- rtl/audio_regs.sv
`timescale 1ns/1ns

module audio_regs (
    input  logic                            clk_audio,
    input  logic                            reset,
    input  audio_pkg::reg_bus_t             bus,
    output logic [audio_pkg::SAMPLE_W-1:0]  rdata,
    output audio_pkg::tone_cfg_t            saw_cfg,
    output audio_pkg::tone_cfg_t            square_cfg,
    output logic                            saw_start,
    output logic                            square_start
);
    import audio_pkg::*;

    logic wr_en;  // Qualified write
    logic rd_en;  // Qualified read

    assign wr_en = bus.select && bus.write;
    assign rd_en = bus.select && bus.read;

    // Register writes and duration strobes
    always_ff @(posedge clk_audio) begin
        if (reset) begin
            saw_cfg.freq        <= DEFAULT_FREQ;
            saw_cfg.duration    <= '0;
            square_cfg.freq     <= DEFAULT_FREQ;
            square_cfg.duration <= '0;
            saw_start           <= 1'b0;
            square_start        <= 1'b0;
        end else begin
            saw_start    <= 1'b0;  // Strobes last one cycle
            square_start <= 1'b0;
            if (wr_en) begin
                case (bus.offset)
                    SAW_FREQ:        saw_cfg.freq <= bus.wdata;
                    SAW_DURATION: begin
                        saw_cfg.duration <= bus.wdata;
                        saw_start        <= 1'b1;  // Kick the sawtooth voice
                    end
                    SQUARE_FREQ:     square_cfg.freq <= bus.wdata;
                    SQUARE_DURATION: begin
                        square_cfg.duration <= bus.wdata;
                        square_start        <= 1'b1;  // Kick the square voice
                    end
                    default: ;  // Unmapped offsets ignored
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rdata = READ_IDLE;
        if (rd_en) begin
            case (bus.offset)
                SAW_FREQ:        rdata = saw_cfg.freq;
                SAW_DURATION:    rdata = saw_cfg.duration;
                SQUARE_FREQ:     rdata = square_cfg.freq;
                SQUARE_DURATION: rdata = square_cfg.duration;
                default:         rdata = READ_IDLE;
            endcase
        end
    end

    // One port write per cycle, so the voices never start together
    assert property (@(posedge clk_audio) disable iff (reset)
        !($rose(saw_start) && $rose(square_start)))
        else $error("audio_regs: both start strobes rose together");

endmodule

//--- rtl/audio_pkg.sv
package audio_pkg;

    // ============================================================
    // Widths and constants
    // ============================================================
    localparam int SAMPLE_W = 16;           // Audio sample and register word
    localparam int PHASE_W  = 32;           // Phase accumulator

    localparam logic [PHASE_W-1:0] PHASE_PER_HZ = 32'd89478;  // ~2^32 / 48000

    localparam logic [SAMPLE_W-1:0] SAW_OFFSET   = 16'h8000;  // Unsigned ramp to signed
    localparam logic [SAMPLE_W-1:0] SQUARE_HIGH  = 16'h3FFF;
    localparam logic [SAMPLE_W-1:0] SQUARE_LOW   = 16'hC000;
    localparam logic [SAMPLE_W-1:0] READ_IDLE    = 16'hFFFF;  // Unmapped or idle read
    localparam logic [SAMPLE_W-1:0] DEFAULT_FREQ = 16'd440;   // Concert A after reset

    localparam int SCLK_HALF         = 4;   // clk_audio cycles per half SCLK
    localparam int SLOTS_PER_CHANNEL = 32;  // SCLK periods per LRCK half

    // ============================================================
    // Enums
    // ============================================================
    typedef enum logic [3:0] {
        SAW_FREQ        = 4'h0,  // Hz
        SAW_DURATION    = 4'h1,  // ms, write starts the voice
        SQUARE_FREQ     = 4'h2,
        SQUARE_DURATION = 4'h3
    } reg_offset_e;

    typedef enum logic [1:0] {
        WAIT_LRCK,    // Idle until the next LRCK edge
        DELAY_FIRST,  // One SCLK period of I2S delay
        TRANSMIT      // Shifting the word out
    } i2s_state_e;

    // ============================================================
    // Structs
    // ============================================================
    typedef struct packed {
        logic                select;
        logic [3:0]          offset;  // Raw offset, may be unmapped
        logic                read;
        logic                write;
        logic [SAMPLE_W-1:0] wdata;
    } reg_bus_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] freq;      // Hz
        logic [SAMPLE_W-1:0] duration;  // ms
    } tone_cfg_t;

    typedef struct packed {
        logic lrck;
        logic sclk;
        logic sdin;
    } i2s_pins_t;

endpackage
